// ==== dll_pkg.sv ====
`default_nettype none

package dll_pkg;

    //////////////////////////////////////////////////
    // sizes and link encoding

    localparam int data_width = 8;
    localparam int max_node   = 8;
    // one code past the last slot serves as the null link
    localparam int addr_width = 4;
    localparam int slot_width = $clog2(max_node);

    localparam logic [addr_width-1:0] addr_null = addr_width'(max_node);

    // length change codes
    localparam logic [1:0] len_hold = 2'd0;
    localparam logic [1:0] len_inc  = 2'd1;
    localparam logic [1:0] len_dec  = 2'd2;

    //////////////////////////////////////////////////
    // enums

    typedef enum logic [2:0] {
        op_read_index   = 3'd0,
        op_insert_index = 3'd1,
        op_delete_index = 3'd2,
        op_delete_value = 3'd3
    } dll_op_e;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_walk_index  = 3'd1,
        st_walk_value  = 3'd2,
        st_insert_link = 3'd3,
        st_done        = 3'd4,
        st_fault       = 3'd5
    } ctrl_state_e;

    //////////////////////////////////////////////////
    // structs

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [addr_width-1:0] next;
        logic [addr_width-1:0] prev;
    } node_t;

    typedef struct packed {
        dll_op_e               op;
        logic [data_width-1:0] data;
        logic [addr_width-1:0] index;
    } dll_cmd_t;

    typedef struct packed {
        logic                  en;
        logic [addr_width-1:0] slot;
        logic [data_width-1:0] data;
        logic                  valid;
    } node_wr_t;

    typedef struct packed {
        logic                  en;
        logic [addr_width-1:0] slot;
        logic [addr_width-1:0] link;
    } link_wr_t;

    typedef struct packed {
        logic                  en;
        logic [addr_width-1:0] head;
        logic [addr_width-1:0] tail;
        logic [1:0]            len_chg;
    } list_update_t;

    typedef struct packed {
        logic [addr_width-1:0] head;
        logic [addr_width-1:0] tail;
        logic [addr_width-1:0] length;
    } list_state_t;

endpackage

`default_nettype wire

// ==== node_store.sv ====
`default_nettype none

module node_store import dll_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   rd_en,
    input  wire [addr_width-1:0]  rd_slot,
    input  wire node_wr_t         node_wr,
    input  wire link_wr_t         next_wr,
    input  wire link_wr_t         prev_wr,
    output node_t                 rd_node,
    output logic                  rd_valid,
    output logic [addr_width-1:0] free_slot,
    output logic [max_node-1:0]   valid_bits
);

    logic [data_width-1:0] node_data [max_node];
    // index 0 holds next links, index 1 prev links
    logic [addr_width-1:0] link_mem [2][max_node];
    link_wr_t              link_wr [2];
    logic [slot_width-1:0] rd_idx;
    logic [slot_width-1:0] node_idx;
    logic                  node_wr_ok;

    assign rd_idx     = rd_slot[slot_width-1:0];
    assign node_idx   = node_wr.slot[slot_width-1:0];
    assign node_wr_ok = node_wr.en && (node_wr.slot != addr_null);
    assign link_wr[0] = next_wr;
    assign link_wr[1] = prev_wr;

    //////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (node_wr_ok) begin
            node_data[node_idx] <= node_wr.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (node_wr_ok) begin
            valid_bits[node_idx] <= node_wr.valid;
        end
    end

    // writes aimed at the null link drop out here
    for (genvar g = 0; g < 2; g++) begin : g_link
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int i = 0; i < max_node; i++) begin
                    link_mem[g][i] <= addr_null;
                end
            end else if (link_wr[g].en && (link_wr[g].slot != addr_null)) begin
                link_mem[g][link_wr[g].slot[slot_width-1:0]] <= link_wr[g].link;
            end
        end
    end

    //////////////////////////////////////////////////
    // registered read

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_node.data <= node_data[rd_idx];
            rd_node.next <= link_mem[0][rd_idx];
            rd_node.prev <= link_mem[1][rd_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (rd_en) begin
            rd_valid <= (rd_slot != addr_null) && valid_bits[rd_idx];
        end
    end

    // lowest invalid slot or null when the pool is full
    always_comb begin
        free_slot = addr_null;
        for (int i = max_node - 1; i >= 0; i--) begin
            if (!valid_bits[i]) begin
                free_slot = addr_width'(i);
            end
        end
    end

    // a new node never lands on a live slot
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        (node_wr_ok && node_wr.valid) |-> !valid_bits[node_idx]);

endmodule

`default_nettype wire

// ==== list_status.sv ====
`default_nettype none

module list_status import dll_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire list_update_t   list_update,
    input  wire [max_node-1:0]  valid_bits,
    output list_state_t         list_state,
    output logic                full,
    output logic                empty
);

    //////////////////////////////////////////////////
    // head, tail and length

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            list_state.head   <= addr_null;
            list_state.tail   <= addr_null;
            list_state.length <= '0;
        end else if (list_update.en) begin
            list_state.head <= list_update.head;
            list_state.tail <= list_update.tail;
            case (list_update.len_chg)
                len_inc: begin
                    list_state.length <= list_state.length + 1'b1;
                end
                len_dec: begin
                    list_state.length <= list_state.length - 1'b1;
                end
                default: begin
                    list_state.length <= list_state.length;
                end
            endcase
        end
    end

    // occupancy straight from the pool
    assign full  = &valid_bits;
    assign empty = ~|valid_bits;

    a_length_bound: assert property (@(posedge clk) disable iff (rst)
        list_state.length <= addr_width'(max_node));

endmodule

`default_nettype wire

// ==== list_ctrl.sv ====
`default_nettype none

module list_ctrl import dll_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   op_start,
    input  wire dll_cmd_t         cmd,
    input  wire list_state_t      list_state,
    input  wire                   full,
    input  wire                   empty,
    input  wire node_t            rd_node,
    input  wire                   rd_valid,
    input  wire [addr_width-1:0]  free_slot,
    output logic                  rd_en,
    output logic [addr_width-1:0] rd_slot,
    output node_wr_t              node_wr,
    output link_wr_t              next_wr,
    output link_wr_t              prev_wr,
    output list_update_t          list_update,
    output logic [data_width-1:0] data_out,
    output logic                  op_done,
    output logic                  fault
);

    ctrl_state_e           state;
    ctrl_state_e           next_state;
    dll_cmd_t              cmd_q;
    logic [addr_width-1:0] cur_slot;
    logic [addr_width-1:0] pos;
    logic [addr_width-1:0] ins_slot;
    logic [addr_width-1:0] ins_prev;
    logic [addr_width-1:0] ins_next;
    logic [addr_width-1:0] ins_prev_d;
    logic [addr_width-1:0] ins_next_d;
    logic                  hit;
    logic                  read_hit;

    // index match on the position walk, data match on the value walk
    assign hit = (state == st_walk_index) ? (pos == cmd_q.index)
                                          : (rd_node.data == cmd_q.data);
    assign read_hit = (state == st_walk_index) && rd_valid && hit
                      && (cmd_q.op == op_read_index);

    //////////////////////////////////////////////////
    // next state and pool accesses

    always_comb begin
        next_state  = state;
        rd_en       = 1'b0;
        rd_slot     = addr_null;
        node_wr     = '0;
        next_wr     = '0;
        prev_wr     = '0;
        ins_prev_d  = addr_null;
        ins_next_d  = addr_null;
        list_update = '{en: 1'b0, head: list_state.head, tail: list_state.tail,
                        len_chg: len_hold};

        case (state)
            st_idle: begin
                if (op_start) begin
                    case (cmd.op)
                        op_insert_index: begin
                            if (full) begin
                                next_state = st_fault;
                            end else if (cmd.index >= list_state.length) begin
                                // append behind the tail even when empty
                                ins_prev_d = list_state.tail;
                                next_state = st_insert_link;
                            end else if (cmd.index == '0) begin
                                ins_next_d = list_state.head;
                                next_state = st_insert_link;
                            end else begin
                                rd_en      = 1'b1;
                                rd_slot    = list_state.head;
                                next_state = st_walk_index;
                            end
                        end
                        op_read_index, op_delete_index: begin
                            if (cmd.index >= list_state.length) begin
                                next_state = st_fault;
                            end else begin
                                rd_en      = 1'b1;
                                rd_slot    = list_state.head;
                                next_state = st_walk_index;
                            end
                        end
                        op_delete_value: begin
                            if (empty) begin
                                next_state = st_fault;
                            end else begin
                                rd_en      = 1'b1;
                                rd_slot    = list_state.head;
                                next_state = st_walk_value;
                            end
                        end
                        default: begin
                            next_state = st_fault;
                        end
                    endcase
                end
            end

            st_walk_index, st_walk_value: begin
                if (!rd_valid) begin
                    next_state = st_fault;
                end else if (hit) begin
                    case (cmd_q.op)
                        op_read_index: begin
                            next_state = st_done;
                        end
                        op_insert_index: begin
                            // new node goes between the matched node and its prev
                            ins_prev_d = rd_node.prev;
                            ins_next_d = cur_slot;
                            next_state = st_insert_link;
                        end
                        default: begin
                            // unlink so the neighbours point past the node
                            node_wr = '{en: 1'b1, slot: cur_slot,
                                        data: rd_node.data, valid: 1'b0};
                            next_wr = '{en: 1'b1, slot: rd_node.prev, link: rd_node.next};
                            prev_wr = '{en: 1'b1, slot: rd_node.next, link: rd_node.prev};
                            list_update.en      = 1'b1;
                            list_update.len_chg = len_dec;
                            if (rd_node.prev == addr_null) begin
                                list_update.head = rd_node.next;
                            end
                            if (rd_node.next == addr_null) begin
                                list_update.tail = rd_node.prev;
                            end
                            next_state = st_done;
                        end
                    endcase
                end else if (rd_node.next == addr_null) begin
                    // walked off the tail
                    next_state = st_fault;
                end else begin
                    rd_en   = 1'b1;
                    rd_slot = rd_node.next;
                end
            end

            st_insert_link: begin
                // neighbours point at the new node
                next_wr = '{en: 1'b1, slot: ins_prev, link: ins_slot};
                prev_wr = '{en: 1'b1, slot: ins_next, link: ins_slot};
                list_update.en      = 1'b1;
                list_update.len_chg = len_inc;
                if (ins_prev == addr_null) begin
                    list_update.head = ins_slot;
                end
                if (ins_next == addr_null) begin
                    list_update.tail = ins_slot;
                end
                next_state = st_done;
            end

            default: begin
                next_state = st_idle;
            end
        endcase

        // first insert cycle writes the node with its own links
        if (next_state == st_insert_link) begin
            node_wr = '{en: 1'b1, slot: free_slot, valid: 1'b1,
                        data: (state == st_idle) ? cmd.data : cmd_q.data};
            next_wr = '{en: 1'b1, slot: free_slot, link: ins_next_d};
            prev_wr = '{en: 1'b1, slot: free_slot, link: ins_prev_d};
        end
    end

    //////////////////////////////////////////////////
    // registers

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cur_slot <= addr_null;
            pos      <= '0;
            op_done  <= 1'b0;
            fault    <= 1'b0;
        end else begin
            state   <= next_state;
            op_done <= (next_state == st_done) || (next_state == st_fault);
            fault   <= (next_state == st_fault);
            if (rd_en) begin
                cur_slot <= rd_slot;
                pos      <= (state == st_idle) ? '0 : pos + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && op_start) begin
            cmd_q <= cmd;
        end
        if (next_state == st_insert_link) begin
            ins_slot <= free_slot;
            ins_prev <= ins_prev_d;
            ins_next <= ins_next_d;
        end
        if (read_hit) begin
            data_out <= rd_node.data;
        end
    end

    // an insert always links a real slot from the pool
    a_insert_has_slot: assert property (@(posedge clk) disable iff (rst)
        (state == st_insert_link) |-> (ins_slot != addr_null));

endmodule

`default_nettype wire

// ==== doubly_linked_list.sv ====
`default_nettype none

module doubly_linked_list import dll_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   op_start,
    input  wire dll_cmd_t         cmd,
    output logic                  op_done,
    output logic                  fault,
    output logic [data_width-1:0] data_out,
    output logic [addr_width-1:0] length,
    output logic                  full,
    output logic                  empty
);

    logic                  rd_en;
    logic [addr_width-1:0] rd_slot;
    node_t                 rd_node;
    logic                  rd_valid;
    node_wr_t              node_wr;
    link_wr_t              next_wr;
    link_wr_t              prev_wr;
    logic [addr_width-1:0] free_slot;
    logic [max_node-1:0]   valid_bits;
    list_update_t          list_update;
    list_state_t           list_state;

    assign length = list_state.length;

    //////////////////////////////////////////////////
    // node pool, status, controller

    node_store node_store_i (
        .clk        (clk),
        .rst        (rst),
        .rd_en      (rd_en),
        .rd_slot    (rd_slot),
        .node_wr    (node_wr),
        .next_wr    (next_wr),
        .prev_wr    (prev_wr),
        .rd_node    (rd_node),
        .rd_valid   (rd_valid),
        .free_slot  (free_slot),
        .valid_bits (valid_bits)
    );

    list_status list_status_i (
        .clk         (clk),
        .rst         (rst),
        .list_update (list_update),
        .valid_bits  (valid_bits),
        .list_state  (list_state),
        .full        (full),
        .empty       (empty)
    );

    list_ctrl list_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .op_start    (op_start),
        .cmd         (cmd),
        .list_state  (list_state),
        .full        (full),
        .empty       (empty),
        .rd_node     (rd_node),
        .rd_valid    (rd_valid),
        .free_slot   (free_slot),
        .rd_en       (rd_en),
        .rd_slot     (rd_slot),
        .node_wr     (node_wr),
        .next_wr     (next_wr),
        .prev_wr     (prev_wr),
        .list_update (list_update),
        .data_out    (data_out),
        .op_done     (op_done),
        .fault       (fault)
    );

endmodule

`default_nettype wire

// ==== tb_list_model.svh ====
`ifndef TB_LIST_MODEL_SVH
`define TB_LIST_MODEL_SVH

//////////////////////////////////////////////////
// reference list with entry 0 as the head

logic [data_width-1:0] model_q[$];
logic [31:0]           lfsr_state;

// applies one command to the model and returns the expected fault
function automatic logic model_exec(input dll_op_e op,
                                    input logic [data_width-1:0] data,
                                    input logic [addr_width-1:0] index,
                                    output logic [data_width-1:0] rd_data);
    int pos;
    int size;
    pos     = int'(index);
    size    = model_q.size();
    rd_data = '0;
    case (op)
        op_read_index: begin
            if (pos >= size) begin
                return 1'b1;
            end
            rd_data = model_q[pos];
        end
        op_insert_index: begin
            if (size == max_node) begin
                return 1'b1;
            end
            // at or past the length the item goes to the tail
            if (pos >= size) begin
                model_q.push_back(data);
            end else begin
                model_q.insert(pos, data);
            end
        end
        op_delete_index: begin
            if (pos >= size) begin
                return 1'b1;
            end
            model_q.delete(pos);
        end
        op_delete_value: begin
            // first match from the head
            for (int i = 0; i < size; i++) begin
                if (model_q[i] == data) begin
                    model_q.delete(i);
                    return 1'b0;
                end
            end
            return 1'b1;
        end
        default: begin
            return 1'b1;
        end
    endcase
    return 1'b0;
endfunction

// galois lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// one lfsr step per bit taken
function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        val = (val << 1) | int'(lfsr_state[0]);
    end
    return val;
endfunction

`endif

// ==== tb_doubly_linked_list.sv ====
`default_nettype none

module tb_doubly_linked_list import dll_pkg::*; ();

    localparam logic [31:0] lfsr_seed      = 32'h1caa;
    localparam int          num_random     = 300;
    localparam int          timeout_cycles = 64;
    localparam int          drive_delay    = 5;

    logic                  clk;
    logic                  rst;
    logic                  op_start;
    dll_cmd_t              cmd;
    logic                  op_done;
    logic                  fault;
    logic [data_width-1:0] data_out;
    logic [addr_width-1:0] length;
    logic                  full;
    logic                  empty;

    // expectation for the command in flight
    string                 cur_name;
    logic                  exp_fault;
    logic                  exp_read;
    logic [data_width-1:0] exp_data;
    int                    errors;
    int                    checks;
    int                    timeouts;

    `include "tb_list_model.svh"

    doubly_linked_list dut_i (
        .clk      (clk),
        .rst      (rst),
        .op_start (op_start),
        .cmd      (cmd),
        .op_done  (op_done),
        .fault    (fault),
        .data_out (data_out),
        .length   (length),
        .full     (full),
        .empty    (empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // reporting

    task automatic log_mismatch(input string name, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", name, field, expected, actual);
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst && op_done) begin
            checks++;
            if (fault !== exp_fault) begin
                log_mismatch(cur_name, "fault", 32'(exp_fault), 32'(fault));
            end
            if (exp_read && !exp_fault && data_out !== exp_data) begin
                log_mismatch(cur_name, "data_out", 32'(exp_data), 32'(data_out));
            end
            if (32'(length) !== 32'(model_q.size())) begin
                log_mismatch(cur_name, "length", 32'(model_q.size()), 32'(length));
            end
            if (full !== (model_q.size() == max_node)) begin
                log_mismatch(cur_name, "full", 32'(model_q.size() == max_node), 32'(full));
            end
            if (empty !== (model_q.size() == 0)) begin
                log_mismatch(cur_name, "empty", 32'(model_q.size() == 0), 32'(empty));
            end
        end
    end

    //////////////////////////////////////////////////
    // command driving

    task automatic run_cmd(input dll_op_e op, input logic [data_width-1:0] data,
                           input logic [addr_width-1:0] index, input string name);
        int                    cycles;
        logic [data_width-1:0] rd_data;
        @(posedge clk);
        #drive_delay;
        exp_fault = model_exec(op, data, index, rd_data);
        exp_data  = rd_data;
        exp_read  = (op == op_read_index);
        cur_name  = name;
        cmd.op    = op;
        cmd.data  = data;
        cmd.index = index;
        op_start  = 1'b1;
        @(posedge clk);
        #drive_delay;
        op_start = 1'b0;
        cycles   = 0;
        while (!op_done && cycles < timeout_cycles) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (!op_done) begin
            timeouts++;
            $display("timeout: %s got no op_done within %0d cycles", name, timeout_cycles);
            finish_run();
        end
    endtask

    task automatic read_all(input string name);
        for (int i = 0; i < model_q.size(); i++) begin
            run_cmd(op_read_index, '0, addr_width'(i), name);
        end
    endtask

    initial begin
        int                    sel;
        dll_op_e               op;
        logic [addr_width-1:0] idx;
        logic [data_width-1:0] val;
        rst        = 1'b1;
        op_start   = 1'b0;
        cmd        = '0;
        cur_name   = "none";
        exp_fault  = 1'b0;
        exp_read   = 1'b0;
        exp_data   = '0;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        lfsr_state = lfsr_seed;
        repeat (10) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        // state right after reset
        @(posedge clk);
        #drive_delay;
        if (length !== '0) begin
            log_mismatch("reset", "length", 32'h0, 32'(length));
        end
        if (empty !== 1'b1) begin
            log_mismatch("reset", "empty", 32'h1, 32'(empty));
        end
        if (full !== 1'b0) begin
            log_mismatch("reset", "full", 32'h0, 32'(full));
        end
        run_cmd(op_read_index, '0, '0, "read empty");

        // insert order
        run_cmd(op_insert_index, 8'h11, 4'd0, "insert front");
        run_cmd(op_insert_index, 8'h22, 4'd9, "insert past end");
        run_cmd(op_insert_index, 8'h33, 4'd1, "insert middle");
        read_all("order");

        // fill up mostly through middle inserts
        while (model_q.size() < max_node) begin
            run_cmd(op_insert_index, data_width'(model_q.size() + 'h80), 4'd2, "fill");
        end
        run_cmd(op_insert_index, 8'hff, 4'd0, "insert full");
        read_all("full");

        //////////////////////////////////////////////////
        // deletes by index
        run_cmd(op_delete_index, '0, 4'd0, "delete head");
        run_cmd(op_delete_index, '0, 4'd3, "delete middle");
        run_cmd(op_delete_index, '0, addr_width'(model_q.size() - 1), "delete tail");
        read_all("after delete");
        run_cmd(op_delete_index, '0, addr_width'(model_q.size()), "delete at length");
        run_cmd(op_delete_index, '0, 4'hf, "delete far");
        while (model_q.size() > 0) begin
            run_cmd(op_delete_index, '0, 4'd0, "drain");
        end
        run_cmd(op_delete_index, '0, 4'd0, "delete empty");

        // deletes by value where the duplicate 05 checks the first match
        run_cmd(op_insert_index, 8'h05, 4'hf, "value setup");
        run_cmd(op_insert_index, 8'h07, 4'hf, "value setup");
        run_cmd(op_insert_index, 8'h05, 4'hf, "value setup");
        run_cmd(op_insert_index, 8'h09, 4'hf, "value setup");
        run_cmd(op_delete_value, 8'h05, '0, "value first match");
        read_all("by value");
        run_cmd(op_delete_value, 8'hee, '0, "value missing");
        run_cmd(op_delete_value, 8'h09, '0, "value tail");
        run_cmd(op_delete_value, 8'h07, '0, "value head");
        run_cmd(op_delete_value, 8'h05, '0, "value last");

        // random mix with a small data range so values repeat
        for (int n = 0; n < num_random; n++) begin
            sel = rand_bits(3);
            idx = addr_width'(rand_bits(3));
            val = data_width'(rand_bits(3) + 'h40);
            case (sel)
                0, 1, 2: op = op_insert_index;
                3, 4:    op = op_read_index;
                5, 6:    op = op_delete_index;
                default: op = op_delete_value;
            endcase
            run_cmd(op, val, idx, $sformatf("random %0d", n));
        end

        @(posedge clk);
        #drive_delay;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== doubly_linked_list.f ====
+incdir+.
dll_pkg.sv
node_store.sv
list_status.sv
list_ctrl.sv
doubly_linked_list.sv
tb_doubly_linked_list.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the list testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_doubly_linked_list \
    -f doubly_linked_list.f -o sim_dll \
    && ./obj_dir/sim_dll | tee /dev/stderr | grep -x "Test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
